// File: compile.f
+incdir+sim
logic/cpu_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/cpu_core.sv
sim/tb_cpu_core.sv

// File: logic/alu.sv
/*
  Combinational ALU. ADD/SUB saturate to 7FFF/8000 and raise V only then.
  Shifts use b[3:0]. LLB/LHB replace a byte of a with b[7:0].
  Z/V/N are raw conditions; execute decides which flags load.
*/

`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  alu_op_e               op,
  input  logic [word_width-1:0] a,
  input  logic [word_width-1:0] b,
  output logic [word_width-1:0] result,
  output logic                  z_set,
  output logic                  v_set,
  output logic                  n_set
);

  localparam int msb     = word_width - 1;
  localparam int nibbles = word_width / 4;
  localparam int red_w   = 7;  // Holds eight 4-bit signed terms

  logic [word_width-1:0]   b_eff;
  logic [word_width-1:0]   sum_raw;
  logic                    sum_ov;
  logic                    pos_ov;
  logic                    neg_ov;
  logic [word_width-1:0]   sum_sat;
  logic signed [red_w-1:0] red_acc;
  logic [word_width-1:0]   red_out;
  logic signed [4:0]       nib_sum;
  logic [word_width-1:0]   paddsb_out;
  logic [2*word_width-1:0] ror_wide;
  logic [word_width-1:0]   shift_out;

  ////////////////////////////////////////////////////////////
  // ADD/SUB with saturation
  ////////////////////////////////////////////////////////////
  assign b_eff   = (op == op_sub) ? ~b : b;                      // Two's complement subtract
  assign sum_raw = a + b_eff + word_width'(op == op_sub);
  assign sum_ov  = (a[msb] == b_eff[msb]) && (sum_raw[msb] != a[msb]);
  assign pos_ov  = sum_ov && !a[msb];
  assign neg_ov  = sum_ov && a[msb];

  always_comb begin
    if (pos_ov) sum_sat = {1'b0, {msb{1'b1}}};        // 7FFF
    else if (neg_ov) sum_sat = {1'b1, {msb{1'b0}}};   // 8000
    else sum_sat = sum_raw;
  end

  // RED: every nibble of a and b as signed, summed, result sign-extended
  always_comb begin
    red_acc = '0;
    for (int i = 0; i < nibbles; i++) begin
      red_acc = red_acc + red_w'($signed(a[4*i +: 4])) + red_w'($signed(b[4*i +: 4]));
    end
    red_out = {{(word_width-red_w){red_acc[red_w-1]}}, red_acc};
  end

  // PADDSB: per-nibble signed add, clamped to 7 and -8
  always_comb begin
    paddsb_out = '0;
    nib_sum    = '0;
    for (int i = 0; i < nibbles; i++) begin
      nib_sum = $signed({a[4*i+3], a[4*i +: 4]}) + $signed({b[4*i+3], b[4*i +: 4]});
      if (nib_sum > 5'sd7) paddsb_out[4*i +: 4] = 4'h7;
      else if (nib_sum < -5'sd8) paddsb_out[4*i +: 4] = 4'h8;
      else paddsb_out[4*i +: 4] = nib_sum[3:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Shifts
  ////////////////////////////////////////////////////////////
  assign ror_wide = {a, a} >> b[3:0];  // Low half is the rotate

  always_comb begin
    case (op)
      op_sll:  shift_out = a << b[3:0];
      op_sra:  shift_out = $signed(a) >>> b[3:0];  // Keeps the sign
      default: shift_out = ror_wide[word_width-1:0];
    endcase
  end

  // Result select
  always_comb begin
    case (op)
      op_add, op_sub:         result = sum_sat;
      op_xor:                 result = a ^ b;
      op_red:                 result = red_out;
      op_sll, op_sra, op_ror: result = shift_out;
      op_paddsb:              result = paddsb_out;
      op_llb:                 result = {a[msb:8], b[7:0]};  // Low byte
      op_lhb:                 result = {b[7:0], a[7:0]};    // High byte
      default:                result = '0;                  // Never issued
    endcase
  end

  assign z_set = (result == '0);
  assign v_set = ((op == op_add) || (op == op_sub)) && sum_ov;  // Only on saturation
  assign n_set = result[msb];

endmodule

// File: logic/cpu_core.sv
/*
  Top of the three-stage execute path: fetch, decode, execute.
  Instructions come in over a read-only Wishbone classic master.
  halted rises once decode reaches HLT; fetch issues nothing after it.
*/

`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
  parameter logic [word_width-1:0] reset_addr = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic [word_width-1:0]     wb_adr,
  input  logic                      wb_ack,
  input  logic [word_width-1:0]     wb_dat,
  output logic                      rf_we,    // One pulse per retired instruction
  output logic [reg_addr_width-1:0] rf_addr,
  output logic [word_width-1:0]     rf_data,
  output logic                      z_flag,
  output logic                      v_flag,
  output logic                      n_flag,
  output logic                      halted
);

  ////////////////////////////////////////////////////////////
  // Stage wires
  ////////////////////////////////////////////////////////////
  logic                      ibuf_valid;
  logic [word_width-1:0]     ibuf_word;
  logic                      ibuf_take;
  logic [reg_addr_width-1:0] rd_addr_a;
  logic [reg_addr_width-1:0] rd_addr_b;
  logic [word_width-1:0]     rd_data_a;
  logic [word_width-1:0]     rd_data_b;
  logic                      ex_valid;
  alu_op_e                   ex_op;
  logic [reg_addr_width-1:0] ex_rd;
  logic [word_width-1:0]     ex_a;
  logic [word_width-1:0]     ex_b;

  fetch_stage #(.reset_addr(reset_addr)) i_fetch_stage (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat,
    .ibuf_valid, .ibuf_word, .ibuf_take, .halted
  );

  decode_stage i_decode_stage (
    .clk, .reset, .ibuf_valid, .ibuf_word, .ibuf_take,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b, .halted
  );

  register_file i_register_file (
    .clk, .reset, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .rf_we, .rf_addr, .rf_data  // Writeback from execute
  );

  execute_stage i_execute_stage (
    .clk, .reset, .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b,
    .rf_we, .rf_addr, .rf_data, .z_flag, .v_flag, .n_flag
  );

endmodule

// File: logic/cpu_pkg.sv
/*
  Shared widths, opcode encoding and instruction layout for the 16-bit model CPU.
  The opcode always sits in the top nibble of the instruction word.
  The flag mask uses bit 2 for Z, bit 1 for V and bit 0 for N.
*/

package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int word_width     = 16;                 // Data and instruction width
  localparam int reg_count      = 16;                 // Architectural registers
  localparam int reg_addr_width = $clog2(reg_count);  // Register index width

  // Bit positions inside a flag mask or a flag set
  localparam int flag_z = 2;
  localparam int flag_v = 1;
  localparam int flag_n = 0;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    op_add    = 4'h0,  // Saturating add
    op_sub    = 4'h1,  // Saturating subtract
    op_xor    = 4'h2,
    op_red    = 4'h3,  // Nibble reduction
    op_sll    = 4'h4,
    op_sra    = 4'h5,
    op_ror    = 4'h6,
    op_paddsb = 4'h7,  // Four saturated nibble adds
    op_lw     = 4'h8,  // No data memory, decoded as no-op
    op_sw     = 4'h9,  // No data memory, decoded as no-op
    op_llb    = 4'hA,
    op_lhb    = 4'hB,
    op_b      = 4'hC,  // Branches not built
    op_br     = 4'hD,
    op_pcs    = 4'hE,
    op_hlt    = 4'hF   // Stops fetch
  } alu_op_e;

  // One instruction word, two field layouts
  typedef union packed {
    struct packed {
      alu_op_e                   op;
      logic [reg_addr_width-1:0] rd;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;  // Also the 4-bit shift amount
    } r_form;
    struct packed {
      alu_op_e                   op;
      logic [reg_addr_width-1:0] rd;
      logic [7:0]                imm;  // LLB and LHB byte
    } i_form;
  } instr_word_t;

  // Which of Z/V/N an opcode is allowed to change
  function automatic logic [2:0] flag_mask_f(input alu_op_e op);
    case (op)
      op_add, op_sub:                 return 3'b111;
      op_xor, op_sll, op_sra, op_ror: return 3'b100;  // Z only
      default:                        return 3'b000;
    endcase
  endfunction

endpackage

// File: logic/decode_stage.sv
/*
  Decode, register read and issue into execute.
  No forwarding: a read of the register held in execute stalls one cycle.
  Data memory, branch and PCS opcodes are consumed and dropped.
  HLT sets halted, which stays high until reset.
*/

`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ibuf_valid,
  input  logic [word_width-1:0]     ibuf_word,
  output logic                      ibuf_take,
  output logic [reg_addr_width-1:0] rd_addr_a,
  output logic [reg_addr_width-1:0] rd_addr_b,
  input  logic [word_width-1:0]     rd_data_a,
  input  logic [word_width-1:0]     rd_data_b,
  output logic                      ex_valid,
  output alu_op_e                   ex_op,
  output logic [reg_addr_width-1:0] ex_rd,
  output logic [word_width-1:0]     ex_a,
  output logic [word_width-1:0]     ex_b,
  output logic                      halted
);

  instr_word_t           instr;
  alu_op_e               op;
  logic                  reads_a;     // Port A value is used
  logic                  reads_b;     // Port B value is used
  logic                  supported;   // Goes to execute
  logic                  load_byte;   // LLB or LHB
  logic [word_width-1:0] b_operand;
  logic                  hazard;
  logic                  issue;

  assign instr     = ibuf_word;
  assign op        = instr.r_form.op;
  assign load_byte = (op == op_llb) || (op == op_lhb);

  // LLB/LHB read rd as the base word
  assign rd_addr_a = load_byte ? instr.i_form.rd : instr.r_form.rs;
  assign rd_addr_b = instr.r_form.rt;

  ////////////////////////////////////////////////////////////
  // Operand sources per opcode
  ////////////////////////////////////////////////////////////
  always_comb begin
    reads_a   = 1'b0;
    reads_b   = 1'b0;
    supported = 1'b0;
    b_operand = rd_data_b;
    case (op)
      op_add, op_sub, op_xor, op_red, op_paddsb: begin
        reads_a   = 1'b1;
        reads_b   = 1'b1;
        supported = 1'b1;
      end
      op_sll, op_sra, op_ror: begin
        reads_a   = 1'b1;
        supported = 1'b1;
        b_operand = {{(word_width-reg_addr_width){1'b0}}, instr.r_form.rt};  // Shift amount
      end
      op_llb, op_lhb: begin
        reads_a   = 1'b1;
        supported = 1'b1;
        b_operand = {{(word_width-8){1'b0}}, instr.i_form.imm};
      end
      default: ;  // Dropped or HLT
    endcase
  end

  // r0 never changes, so a pending write to it is no hazard
  assign hazard = ex_valid && (ex_rd != '0) &&
                  ((reads_a && (rd_addr_a == ex_rd)) || (reads_b && (rd_addr_b == ex_rd)));

  assign ibuf_take = ibuf_valid && !halted && !hazard;
  assign issue     = ibuf_take && supported;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      ex_valid <= issue;                               // One cycle per instruction
      if (ibuf_take && (op == op_hlt)) halted <= 1'b1;  // Sticky
    end
  end

  // Decode-to-execute payload
  always_ff @(posedge clk) begin
    if (issue) begin
      ex_op <= op;
      ex_rd <= instr.r_form.rd;
      ex_a  <= rd_data_a;
      ex_b  <= b_operand;
    end
  end

endmodule

// File: logic/execute_stage.sv
/*
  Execute: ALU, writeback register and the Z/V/N flag register.
  rf_we pulses one cycle per issued instruction.
  Flags load on the edge that ends that pulse, masked per opcode.
*/

`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ex_valid,
  input  alu_op_e                   ex_op,
  input  logic [reg_addr_width-1:0] ex_rd,
  input  logic [word_width-1:0]     ex_a,
  input  logic [word_width-1:0]     ex_b,
  output logic                      rf_we,
  output logic [reg_addr_width-1:0] rf_addr,
  output logic [word_width-1:0]     rf_data,
  output logic                      z_flag,
  output logic                      v_flag,
  output logic                      n_flag
);

  logic [word_width-1:0] alu_result;
  logic                  z_set;
  logic                  v_set;
  logic                  n_set;
  logic [2:0]            mask_q;   // Flags this instruction may load
  logic [2:0]            set_q;    // Z/V/N values waiting for the write edge

  alu i_alu (
    .op     (ex_op),
    .a      (ex_a),
    .b      (ex_b),
    .result (alu_result),
    .z_set  (z_set),
    .v_set  (v_set),
    .n_set  (n_set)
  );

  // Writeback payload, flags travel with it
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      rf_addr <= ex_rd;
      rf_data <= alu_result;
      mask_q  <= flag_mask_f(ex_op);
      set_q   <= {z_set, v_set, n_set};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rf_we  <= 1'b0;
      z_flag <= 1'b0;
      v_flag <= 1'b0;
      n_flag <= 1'b0;
    end else begin
      rf_we <= ex_valid;
      if (rf_we) begin  // Same edge as the register write
        if (mask_q[flag_z]) z_flag <= set_q[flag_z];
        if (mask_q[flag_v]) v_flag <= set_q[flag_v];
        if (mask_q[flag_n]) n_flag <= set_q[flag_n];
      end
    end
  end

endmodule

// File: logic/fetch_stage.sv
/*
  Instruction fetch over a read-only Wishbone classic master.
  One access at a time, stb drops for at least one cycle between accesses.
  Stops issuing once a HLT sits in the buffer or halted is high.
*/

`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; #(
  parameter logic [word_width-1:0] reset_addr = '0  // PC after reset
) (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic [word_width-1:0] wb_adr,      // Word address
  input  logic                  wb_ack,
  input  logic [word_width-1:0] wb_dat,
  output logic                  ibuf_valid,
  output logic [word_width-1:0] ibuf_word,
  input  logic                  ibuf_take,   // Decode consumes the buffer this cycle
  input  logic                  halted
);

  localparam logic st_idle = 1'b0;
  localparam logic st_wait = 1'b1;  // Bus cycle open, waiting on ack

  logic                  state;
  logic [word_width-1:0] pc;
  instr_word_t           buf_instr;
  logic                  hlt_buffered;
  logic                  start;
  logic                  done;

  assign buf_instr    = ibuf_word;
  assign hlt_buffered = ibuf_valid && (buf_instr.r_form.op == op_hlt);  // Nothing past HLT

  // New access only when the buffer will be free for the result
  assign start = !halted && !hlt_buffered && (!ibuf_valid || ibuf_take);
  assign done  = (state == st_wait) && wb_ack;

  assign wb_cyc = (state == st_wait);
  assign wb_stb = (state == st_wait);
  assign wb_adr = pc;  // Holds through the whole cycle

  ////////////////////////////////////////////////////////////
  // Bus FSM and program counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      pc    <= reset_addr;
    end else begin
      case (state)
        st_idle: if (start) state <= st_wait;
        st_wait: begin
          if (wb_ack) begin
            state <= st_idle;    // Forces the idle gap on stb
            pc    <= pc + 1'b1;  // One word per access
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Buffer valid, set on ack, cleared when decode takes it
  always_ff @(posedge clk) begin
    if (reset) begin
      ibuf_valid <= 1'b0;
    end else if (done) begin
      ibuf_valid <= 1'b1;
    end else if (ibuf_take) begin
      ibuf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (done) ibuf_word <= wb_dat;  // Data taken on the ack edge
  end

endmodule

// File: logic/register_file.sv
/*
  Register file, two read ports and one write port.
  r0 reads as zero and ignores writes.
  A read of the register being written returns the new data in the same cycle.
*/

`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] rd_addr_a,
  input  logic [reg_addr_width-1:0] rd_addr_b,
  output logic [word_width-1:0]     rd_data_a,
  output logic [word_width-1:0]     rd_data_b,
  input  logic                      rf_we,
  input  logic [reg_addr_width-1:0] rf_addr,
  input  logic [word_width-1:0]     rf_data
);

  logic [word_width-1:0] regs [reg_count];

  // Shared by both read ports
  function automatic logic [word_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) return '0;                  // Zero register
    if (rf_we && (rf_addr == addr)) return rf_data;  // Write-through
    return regs[addr];
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (rf_we && (rf_addr != '0)) begin
      regs[rf_addr] <= rf_data;
    end
  end

endmodule

// File: sim/tb_cpu_model.svh
/*
  Sequential model of the CPU for the testbench: LFSR, ALU reference, program generator.
  Included inside tb_cpu_core and works on its mem, lfsr_state and exp_q.
  Random code uses r0..r7 only, so dependent neighbours come up often.
*/
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// Galois LFSR, taps 16 14 13 11
function automatic logic lfsr_bit();
  logic out;
  out        = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) lfsr_state = lfsr_state ^ 16'hB400;
  return out;
endfunction

function automatic logic [15:0] lfsr_draw(input int bits);
  logic [15:0] val;
  val = '0;
  for (int i = 0; i < bits; i++) val = {val[14:0], lfsr_bit()};  // One step per bit
  return val;
endfunction

function automatic int nib_value(input logic [3:0] n);
  return n[3] ? int'(n) - 16 : int'(n);  // Two's complement nibble
endfunction

// Expected {result, Z, V, N} of one supported opcode
function automatic logic [18:0] ref_alu(input alu_op_e op, input logic [15:0] a,
                                        input logic [15:0] b);
  int          sum;
  logic [15:0] res;
  logic        ovf;
  res = '0;
  ovf = 1'b0;
  case (op)
    op_add, op_sub: begin
      sum = (op == op_add) ? int'($signed(a)) + int'($signed(b))
                           : int'($signed(a)) - int'($signed(b));
      ovf = (sum > 32767) || (sum < -32768);
      res = (sum > 32767) ? 16'h7FFF : (sum < -32768) ? 16'h8000 : sum[15:0];
    end
    op_xor: res = a ^ b;
    op_red: begin
      sum = 0;
      for (int i = 0; i < 4; i++) sum += nib_value(a[4*i +: 4]) + nib_value(b[4*i +: 4]);
      res = sum[15:0];
    end
    op_sll: res = a << b[3:0];
    op_sra: begin
      sum = int'($signed(a)) >>> b[3:0];
      res = sum[15:0];
    end
    op_ror: res = (b[3:0] == 0) ? a : (a >> b[3:0]) | (a << (16 - b[3:0]));
    op_paddsb: begin
      for (int i = 0; i < 4; i++) begin
        sum = nib_value(a[4*i +: 4]) + nib_value(b[4*i +: 4]);
        sum = (sum > 7) ? 7 : (sum < -8) ? -8 : sum;  // Clamp per lane
        res[4*i +: 4] = sum[3:0];
      end
    end
    op_llb: res = {a[15:8], b[7:0]};
    op_lhb: res = {b[7:0], a[7:0]};
    default: res = '0;
  endcase
  return {res, res == 16'h0000, ovf, res[15]};
endfunction

// Flags an opcode writes, Z V N
function automatic logic [2:0] flags_written(input alu_op_e op);
  if (op inside {op_add, op_sub}) return 3'b111;
  if (op inside {op_xor, op_sll, op_sra, op_ror}) return 3'b100;
  return 3'b000;
endfunction

// Seeds r1..r7 with LLB/LHB, then random code, HLT in the last word
task automatic build_program();
  instr_word_t iw;
  for (int r = 1; r < 8; r++) begin
    iw.i_form.op  = op_llb;
    iw.i_form.rd  = 4'(r);
    iw.i_form.imm = 8'(lfsr_draw(8));
    mem[2*r-2]    = iw;
    iw.i_form.op  = op_lhb;
    iw.i_form.imm = 8'(lfsr_draw(8));
    mem[2*r-1]    = iw;
  end
  for (int p = 14; p < mem_words - 1; p++) begin
    iw.r_form.op = alu_op_e'(4'(lfsr_draw(4)));
    if (iw.r_form.op == op_hlt) iw.r_form.op = op_sub;  // HLT only at the end
    iw.r_form.rd = 4'(lfsr_draw(3));
    iw.r_form.rs = 4'(lfsr_draw(3));
    iw.r_form.rt = 4'(lfsr_draw((iw.r_form.op inside {op_sll, op_sra, op_ror}) ? 4 : 3));
    if (iw.r_form.op inside {op_llb, op_lhb}) iw.i_form.imm = 8'(lfsr_draw(8));
    mem[p] = iw;
  end
  mem[mem_words-1] = {op_hlt, 12'h000};
endtask

// Runs the program in order, one record per issued instruction
task automatic run_model();
  logic [15:0] regs [16];
  instr_word_t iw;
  logic [15:0] a;
  logic [15:0] b;
  logic [18:0] out;
  logic [2:0]  mask;
  logic [2:0]  flags;
  expect_t     rec;
  flags = 3'b000;
  for (int r = 0; r < 16; r++) regs[r] = '0;
  for (int p = 0; p < mem_words; p++) begin
    iw = mem[p];
    if (iw.r_form.op == op_hlt) break;
    if (iw.r_form.op inside {op_lw, op_sw, op_b, op_br, op_pcs}) continue;  // Never issued
    a = regs[iw.r_form.rs];
    b = regs[iw.r_form.rt];
    if (iw.r_form.op inside {op_sll, op_sra, op_ror}) b = {12'h000, iw.r_form.rt};
    if (iw.r_form.op inside {op_llb, op_lhb}) begin
      a = regs[iw.i_form.rd];  // Base word is rd
      b = {8'h00, iw.i_form.imm};
    end
    out   = ref_alu(iw.r_form.op, a, b);
    mask  = flags_written(iw.r_form.op);
    flags = (flags & ~mask) | (out[2:0] & mask);
    if (iw.r_form.rd != 0) regs[iw.r_form.rd] = out[18:3];  // r0 stays zero
    rec.addr  = iw.r_form.rd;
    rec.data  = out[18:3];
    rec.flags = flags;
    exp_q.push_back(rec);
  end
endtask

`endif

// File: sim/tb_cpu_core.sv
/*
  Testbench for cpu_core with a random program from a seeded LFSR.
  The Wishbone memory adds 0..3 wait states per access.
  Writebacks are compared in order with the model and flags one cycle later.
  The run stops at the first mismatch.
*/

`timescale 1ns/100ps

module tb_cpu_core import cpu_pkg::*; ();

  typedef struct packed {
    logic [3:0]  addr;
    logic [15:0] data;
    logic [2:0]  flags;  // Z V N after this instruction
  } expect_t;

  localparam int mem_words      = 64;
  localparam int reset_cycles   = 10;
  localparam int timeout_cycles = mem_words * 10 + reset_cycles;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic [15:0] wb_adr;
  logic        wb_ack;
  logic [15:0] wb_dat;
  logic        rf_we;
  logic [3:0]  rf_addr;
  logic [15:0] rf_data;
  logic        z_flag;
  logic        v_flag;
  logic        n_flag;
  logic        halted;

  logic [15:0] mem [mem_words];
  logic [15:0] lfsr_state;
  expect_t     exp_q[$];
  int          expected_count;
  int          we_count;
  int          cycle_count;
  int          wait_left;
  logic        bus_busy;
  logic        flag_pending;
  logic [2:0]  flag_want;

  `include "tb_cpu_model.svh"

  cpu_core #(.reset_addr(16'h0000)) i_cpu_core (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat,
    .rf_we, .rf_addr, .rf_data, .z_flag, .v_flag, .n_flag, .halted
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
      abort_run("mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone memory, acts 2 ns after each edge
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #2;
    if (wb_ack) begin
      wb_ack   = 1'b0;  // Data taken on the edge just passed
      bus_busy = 1'b0;
    end else if ((wb_cyc === 1'b1) && (wb_stb === 1'b1)) begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        wait_left = lfsr_draw(2);  // 0..3 wait states
      end
      if (wait_left == 0) begin
        if (wb_adr >= mem_words) abort_run($sformatf("fetch past program end at 0x%0h", wb_adr));
        wb_ack = 1'b1;
        wb_dat = mem[wb_adr];
      end else begin
        wait_left--;
      end
    end
  end

  // Writeback compare, flags one cycle after rf_we
  always @(posedge clk) begin
    expect_t rec;
    #2;
    if (flag_pending) begin
      expect_equal("z_flag", z_flag, flag_want[2]);
      expect_equal("v_flag", v_flag, flag_want[1]);
      expect_equal("n_flag", n_flag, flag_want[0]);
      flag_pending = 1'b0;
    end
    if (rf_we === 1'b1) begin
      if (exp_q.size() == 0) abort_run("rf_we pulsed with no instruction left in the model");
      rec = exp_q.pop_front();
      we_count++;
      expect_equal("rf_addr", rf_addr, rec.addr);
      expect_equal("rf_data", rf_data, rec.data);
      flag_want    = rec.flags;
      flag_pending = 1'b1;
    end
    if ((halted === 1'b1) && (wb_stb === 1'b1)) abort_run("wb_stb raised after halted");
  end

  // Cycle limit, generous for 64 fetches with wait states
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) abort_run("timeout, program did not halt and drain");
  end

  initial begin
    reset          = 1'b1;
    wb_ack         = 1'b0;
    wb_dat         = '0;
    bus_busy       = 1'b0;
    flag_pending   = 1'b0;
    flag_want      = '0;
    wait_left      = 0;
    we_count       = 0;
    cycle_count    = 0;
    lfsr_state     = 16'd38;
    build_program();
    run_model();
    expected_count = exp_q.size();
    repeat (reset_cycles) @(posedge clk);
    #2;
    expect_equal("wb_cyc", wb_cyc, 0);  // Reset state
    expect_equal("rf_we", rf_we, 0);
    expect_equal("halted", halted, 0);
    expect_equal("flags", {z_flag, v_flag, n_flag}, 0);
    reset = 1'b0;
    do begin
      @(posedge clk);
      #3;
    end while (halted !== 1'b1);  // Last writeback is already out when halted rises
    repeat (4) @(posedge clk);  // Quiet tail, any stray rf_we or stb fails
    #3;
    expect_equal("rf_we count", we_count, expected_count);
    $display("** PASS **");
    $finish;
  end

endmodule
